/* vlog.f */
+incdir+verification
rtl/noc_if_pkg.sv
rtl/packet_fifo.sv
rtl/request_packetizer.sv
rtl/response_depacketizer.sv
rtl/reorder_buffer.sv
rtl/noc_master_interface.sv
verification/tb_noc_master_interface.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the NoC master interface testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_noc_master_interface -o tb_sim \
	&& ./obj_dir/tb_sim | tee sim.log

grep -qx "Test OK" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* verification/tb_noc_model.svh */
`ifndef TB_NOC_MODEL_SVH
`define TB_NOC_MODEL_SVH

// Fibonacci LFSR with taps 16 14 13 11
logic [15:0] lfsr_state = 16'd30;

// One LFSR step for every bit handed out
function automatic logic [127:0] lfsr_bits(input int n);
	logic [127:0] v;
	logic         fb;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		v          = {v[126:0], fb};
	end
	return v;
endfunction

// Slave k from address bits [5:4] answers on node 4+k
function automatic logic [2:0] slave_dst(input logic [31:0] addr);
	return 3'd4 + {1'b0, addr[5:4]};
endfunction

// Request packet as the master side should emit it
function automatic noc_packet_t req_pkt(input ptype_e t, input logic [127:0] data,
	input logic [2:0] id, input logic [2:0] seq, input logic [2:0] dst);
	noc_packet_t p;
	p       = '0;                      // Pad stays zero
	p.data  = data;
	p.id    = id;
	p.seq   = seq;
	p.src   = MASTER_ID;
	p.dst   = dst;
	p.ptype = t;
	p.valid = 1'b1;
	return p;
endfunction

// Response packet from a slave back to this master
function automatic noc_packet_t resp_pkt(input ptype_e t, input logic [2:0] seq,
	input logic [2:0] id, input logic [127:0] data, input logic [2:0] src);
	noc_packet_t p;
	p = req_pkt(t, data, id, seq, MASTER_ID);
	p.src = src;                       // Write responses are matched on it
	return p;
endfunction

`endif

/* verification/tb_noc_master_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_noc_master_interface;
	import noc_if_pkg::*;

	localparam logic [2:0] MASTER_ID = 3'd1;
	localparam int DEPTH          = 8;      // Both FIFOs and both reorder buffers
	localparam int CLK_PERIOD     = 40;
	localparam int WRITE_CYCLES   = 200;    // Per-test budgets for the watchdog
	localparam int READ_CYCLES    = 200;
	localparam int BP_CYCLES      = 120;
	localparam int CAP_CYCLES     = 250;
	localparam int TIMEOUT_CYCLES = 10 + WRITE_CYCLES + READ_CYCLES + BP_CYCLES + CAP_CYCLES;

	`include "tb_noc_model.svh"

	logic        ACLK;
	logic        ARESETn;
	aw_req_t     aw;
	logic        aw_valid;
	logic        aw_ready;
	w_req_t      w;
	logic        w_valid;
	logic        w_ready;
	ar_req_t     ar;
	logic        ar_valid;
	logic        ar_ready;
	r_resp_t     r;
	logic        r_valid;
	logic        r_ready;
	b_resp_t     b;
	logic        b_valid;
	logic        b_ready;
	noc_packet_t noc_out;
	logic        noc_out_valid;
	logic        noc_out_ready;
	noc_packet_t noc_in;
	logic        noc_in_valid;
	logic        noc_in_ready;

	noc_packet_t out_q [$];                 // Packets seen leaving toward the router
	logic [2:0]  wr_ids [$];                // Outstanding writes in AW order
	wr_tag_t     wr_tags [$];
	logic [2:0]  rd_ids [$];                // Outstanding reads in AR order
	logic [2:0]  rd_seqs [$];
	logic [2:0]  wr_cnt [4] = '{default: '0};   // Model of the per-slave sequence
	logic [2:0]  rd_cnt = '0;
	logic [2:0]  last_seq = '0;             // Seq and dst that a W beat inherits
	logic [2:0]  last_dst = '0;
	int          order [16];
	int          checks = 0;
	int          errors = 0;

	noc_master_interface #(.MASTER_ID(MASTER_ID), .FIFO_DEPTH(DEPTH), .ROB_DEPTH(DEPTH)) DUT (.*);

	initial
	begin
		ACLK = 1'b0;
		forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
	end

	// Sampled mid-cycle before the transfer edge
	always @(negedge ACLK)
		if (noc_out_valid && noc_out_ready)
			out_q.push_back(noc_out);

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic check_value(input string name, input logic [159:0] got,
		input logic [159:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, want, $time);
		end
	endtask

	// Called and returns 2 ns after a rising edge
	task automatic send_req(input ptype_e kind, input logic [2:0] id, input logic [127:0] val);
		aw       = '{id: id, addr: val[31:0]};
		w        = '{id: id, data: val};
		ar       = '{id: id, addr: val[31:0]};
		aw_valid = (kind == PT_WR_ADDR);
		w_valid  = (kind == PT_WR_DATA);
		ar_valid = (kind == PT_RD_ADDR);
		@(negedge ACLK);
		while (!(aw_valid && aw_ready || w_valid && w_ready || ar_valid && ar_ready))
			@(negedge ACLK);
		@(posedge ACLK);
		#2;
		aw_valid = 1'b0;
		w_valid  = 1'b0;
		ar_valid = 1'b0;
	endtask

	task automatic send_resp(input noc_packet_t p);
		noc_in       = p;
		noc_in_valid = 1'b1;
		@(negedge ACLK);
		while (!noc_in_ready)
			@(negedge ACLK);
		@(posedge ACLK);
		#2;
		noc_in_valid = 1'b0;
	endtask

	task automatic take_resp(input logic is_read, output logic [130:0] v);
		r_ready = is_read;
		b_ready = !is_read;
		@(negedge ACLK);
		while (!(is_read ? r_valid : b_valid))
			@(negedge ACLK);
		v = is_read ? 131'(r) : 131'(b);   // Retires on the coming edge
		@(posedge ACLK);
		#2;
		r_ready = 1'b0;
		b_ready = 1'b0;
	endtask

	task automatic pop_packet(output noc_packet_t p);
		while (out_q.size() == 0)
		begin
			@(posedge ACLK);
			#2;
		end
		p = out_q.pop_front();
	endtask

	// Fisher-Yates over 0..n-1 unless mix is low
	function automatic void shuffle_order(input int n, input logic mix);
		int j;
		int t;
		for (int i = 0; i < n; i++)
			order[i] = i;
		for (int i = n - 1; i > 0 && mix; i--)
		begin
			j        = int'(lfsr_bits(8)) % (i + 1);
			t        = order[i];
			order[i] = order[j];
			order[j] = t;
		end
	endfunction

	// ------------------------------
	// Request and response sequences
	// ------------------------------
	task automatic issue_writes(input int n);
		logic [31:0]  addr;
		logic [127:0] data;
		logic [2:0]   id;
		logic [1:0]   sel;
		noc_packet_t  p;
		for (int i = 0; i < n; i++)
		begin
			sel       = 2'(i);                  // Walks all four slaves
			addr      = 32'(lfsr_bits(32));
			addr[5:4] = sel;
			id        = 3'(lfsr_bits(3));
			data      = lfsr_bits(128);
			send_req(PT_WR_ADDR, id, {96'd0, addr});
			pop_packet(p);
			check_value("noc_out aw", p,
				req_pkt(PT_WR_ADDR, {96'd0, addr}, id, wr_cnt[sel], slave_dst(addr)));
			send_req(PT_WR_DATA, id, data);
			pop_packet(p);
			check_value("noc_out w", p,
				req_pkt(PT_WR_DATA, data, id, wr_cnt[sel], slave_dst(addr)));
			wr_ids.push_back(id);
			wr_tags.push_back('{seq: wr_cnt[sel], dst: slave_dst(addr)});
			last_seq    = wr_cnt[sel];
			last_dst    = slave_dst(addr);
			wr_cnt[sel] = wr_cnt[sel] + 3'd1;   // Wraps modulo 8
		end
	endtask

	task automatic return_writes(input int n);
		logic [1:0]   resp [16];
		logic [130:0] v;
		wr_tag_t      tag;
		shuffle_order(n, 1'b1);
		for (int i = 0; i < n; i++)
			resp[i] = 2'(lfsr_bits(2));
		for (int i = 0; i < n; i++)
		begin
			tag = wr_tags[order[i]];
			send_resp(resp_pkt(PT_WR_RESP, tag.seq, wr_ids[order[i]], 128'(resp[order[i]]),
				tag.dst));
		end
		for (int i = 0; i < n; i++)
		begin
			take_resp(1'b0, v);
			check_value("b", 160'(v), 160'({wr_ids[i], resp[i]}));
		end
		repeat (n)
		begin
			void'(wr_ids.pop_front());
			void'(wr_tags.pop_front());
		end
	endtask

	task automatic issue_reads(input int n);
		logic [31:0] addr;
		logic [2:0]  id;
		noc_packet_t p;
		for (int i = 0; i < n; i++)
		begin
			addr = 32'(lfsr_bits(32));
			id   = 3'(lfsr_bits(3));
			send_req(PT_RD_ADDR, id, {96'd0, addr});
			pop_packet(p);
			check_value("noc_out ar", p,
				req_pkt(PT_RD_ADDR, {96'd0, addr}, id, rd_cnt, slave_dst(addr)));
			rd_ids.push_back(id);
			rd_seqs.push_back(rd_cnt);
			rd_cnt = rd_cnt + 3'd1;
		end
	endtask

	task automatic return_reads(input int n, input logic mix);
		logic [127:0] data [16];
		logic [130:0] v;
		shuffle_order(n, mix);
		for (int i = 0; i < n; i++)
			data[i] = lfsr_bits(128);
		for (int i = 0; i < n; i++)
			send_resp(resp_pkt(PT_RD_DATA, rd_seqs[order[i]], rd_ids[order[i]],
				data[order[i]], 3'd4));
		for (int i = 0; i < n; i++)
		begin
			take_resp(1'b1, v);
			check_value("r", 160'(v), 160'({rd_ids[i], data[i]}));
		end
		repeat (n)
		begin
			void'(rd_ids.pop_front());
			void'(rd_seqs.pop_front());
		end
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic writes_in_order();
		issue_writes(DEPTH);
		return_writes(DEPTH);                // Shuffled across slaves
	endtask

	task automatic reads_in_order();
		issue_reads(DEPTH);
		return_reads(DEPTH, 1'b1);
	endtask

	// W beats pile up behind a stalled router until the readies drop
	task automatic backpressure();
		noc_packet_t  want [DEPTH+1];
		noc_packet_t  p;
		logic [127:0] data;
		logic [2:0]   id;
		noc_out_ready = 1'b0;
		for (int i = 0; i <= DEPTH; i++)
		begin
			data    = lfsr_bits(128);
			id      = 3'(lfsr_bits(3));
			want[i] = req_pkt(PT_WR_DATA, data, id, last_seq, last_dst);
			if (i < DEPTH)
				send_req(PT_WR_DATA, id, data);
			else
				fork
					send_req(PT_WR_DATA, id, data);   // Held until the router drains
					begin
						repeat (4)
						begin
							@(negedge ACLK);
							check_value("w_ready", 160'(w_ready), '0);
						end
						@(posedge ACLK);
						#2;
						noc_out_ready = 1'b1;
					end
				join
		end
		for (int i = 0; i <= DEPTH; i++)
		begin
			pop_packet(p);
			check_value("noc_out stalled", p, want[i]);
		end
	endtask

	// Full read reorder buffer holds back the next AR
	task automatic rob_capacity();
		issue_reads(DEPTH);
		fork
			issue_reads(1);
			begin
				repeat (4)
				begin
					@(negedge ACLK);
					check_value("ar_ready", 160'(ar_ready), '0);
				end
				@(posedge ACLK);
				#2;
				return_reads(1, 1'b0);         // Oldest read retires
			end
		join
		return_reads(DEPTH, 1'b1);
	endtask

	initial
	begin
		ACLK          = 1'b0;
		ARESETn       = 1'b0;
		aw            = '0;
		w             = '0;
		ar            = '0;
		noc_in        = '0;
		aw_valid      = 1'b0;
		w_valid       = 1'b0;
		ar_valid      = 1'b0;
		noc_in_valid  = 1'b0;
		r_ready       = 1'b0;
		b_ready       = 1'b0;
		noc_out_ready = 1'b1;
		repeat (10) @(posedge ACLK);
		#2;
		ARESETn = 1'b1;
		@(negedge ACLK);
		check_value("idle outputs",
			160'({aw_ready, w_ready, ar_ready, noc_in_ready, noc_out_valid, r_valid, b_valid}),
			160'(7'b1111000));
		@(posedge ACLK);
		#2;
		writes_in_order();
		reads_in_order();
		backpressure();
		rob_capacity();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/noc_master_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_master_interface #(
	parameter logic [noc_if_pkg::NODE_W-1:0] MASTER_ID = '0,
	parameter int FIFO_DEPTH = 8,
	parameter int ROB_DEPTH  = 8
) (
	input  logic                    ACLK,
	input  logic                    ARESETn,
	input  noc_if_pkg::aw_req_t     aw,
	input  logic                    aw_valid,
	output logic                    aw_ready,
	input  noc_if_pkg::w_req_t      w,
	input  logic                    w_valid,
	output logic                    w_ready,
	input  noc_if_pkg::ar_req_t     ar,
	input  logic                    ar_valid,
	output logic                    ar_ready,
	output noc_if_pkg::r_resp_t     r,
	output logic                    r_valid,
	input  logic                    r_ready,
	output noc_if_pkg::b_resp_t     b,
	output logic                    b_valid,
	input  logic                    b_ready,
	output noc_if_pkg::noc_packet_t noc_out,
	output logic                    noc_out_valid,
	input  logic                    noc_out_ready,
	input  noc_if_pkg::noc_packet_t noc_in,
	input  logic                    noc_in_valid,
	output logic                    noc_in_ready
);
	import noc_if_pkg::*;

	noc_packet_t pkt;                      // Packet register
	logic        pkt_valid;
	logic        out_empty;
	logic        out_full;
	logic        out_one_free;
	noc_packet_t in_head;
	logic        in_empty;
	logic        in_full;
	logic        in_pop;
	logic        wr_alloc;
	wr_tag_t     wr_alloc_tag;
	logic        rd_alloc;
	rd_tag_t     rd_alloc_tag;
	logic        wr_rob_not_full;
	logic        rd_rob_not_full;
	logic        rd_fill;
	rd_tag_t     rd_fill_tag;
	r_resp_t     rd_fill_data;
	logic        wr_fill;
	wr_tag_t     wr_fill_tag;
	b_resp_t     wr_fill_data;

	// ------------------------------
	// Request path toward the router
	// ------------------------------
	request_packetizer #(.MASTER_ID(MASTER_ID)) u_packetizer (
		.ACLK, .ARESETn, .aw, .aw_valid, .aw_ready, .w, .w_valid, .w_ready,
		.ar, .ar_valid, .ar_ready,
		.fifo_full(out_full), .fifo_one_free(out_one_free),
		.wr_rob_not_full, .rd_rob_not_full, .pkt, .pkt_valid,
		.wr_alloc, .wr_alloc_tag, .rd_alloc, .rd_alloc_tag
	);

	assign noc_out_valid = !out_empty;
	packet_fifo #(.DEPTH(FIFO_DEPTH), .T(noc_packet_t)) u_out_fifo (
		.ACLK, .ARESETn, .put(pkt_valid), .get(noc_out_valid && noc_out_ready),
		.din(pkt), .dout(noc_out), .empty(out_empty), .full(out_full),
		.one_free(out_one_free)
	);

	// ------------------------------
	// Response path from the router
	// ------------------------------
	assign noc_in_ready = !in_full;
	packet_fifo #(.DEPTH(FIFO_DEPTH), .T(noc_packet_t)) u_in_fifo (
		.ACLK, .ARESETn, .put(noc_in_valid && noc_in_ready), .get(in_pop),
		.din(noc_in), .dout(in_head), .empty(in_empty), .full(in_full), .one_free()
	);

	response_depacketizer u_depacketizer (
		.ACLK, .ARESETn, .pkt(in_head), .pkt_avail(!in_empty), .pop(in_pop),
		.rd_fill, .rd_fill_tag, .rd_fill_data, .wr_fill, .wr_fill_tag, .wr_fill_data
	);

	// Reads and writes retire in their own issue order
	reorder_buffer #(.DEPTH(ROB_DEPTH), .TAG_T(rd_tag_t), .DATA_T(r_resp_t)) u_rd_rob (
		.ACLK, .ARESETn, .alloc(rd_alloc), .alloc_tag(rd_alloc_tag),
		.fill(rd_fill), .fill_tag(rd_fill_tag), .fill_data(rd_fill_data),
		.out_ready(r_ready), .not_full(rd_rob_not_full), .out(r), .out_valid(r_valid)
	);

	reorder_buffer #(.DEPTH(ROB_DEPTH), .TAG_T(wr_tag_t), .DATA_T(b_resp_t)) u_wr_rob (
		.ACLK, .ARESETn, .alloc(wr_alloc), .alloc_tag(wr_alloc_tag),
		.fill(wr_fill), .fill_tag(wr_fill_tag), .fill_data(wr_fill_data),
		.out_ready(b_ready), .not_full(wr_rob_not_full), .out(b), .out_valid(b_valid)
	);

endmodule

`default_nettype wire

/* rtl/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
	parameter int  DEPTH  = 8,             // Power of two
	parameter type TAG_T  = logic [2:0],
	parameter type DATA_T = logic [7:0]
) (
	input  logic  ACLK,
	input  logic  ARESETn,
	input  logic  alloc,                   // New request in issue order
	input  TAG_T  alloc_tag,
	input  logic  fill,                    // Response in any order
	input  TAG_T  fill_tag,
	input  DATA_T fill_data,
	input  logic  out_ready,
	output logic  not_full,
	output DATA_T out,
	output logic  out_valid
);
	localparam int PTR_W = $clog2(DEPTH);

	logic [DEPTH-1:0] alloc_q;             // Entry waits for a response
	logic [DEPTH-1:0] filled_q;            // Response has landed
	TAG_T             tag_q  [DEPTH];
	DATA_T            data_q [DEPTH];
	logic [PTR_W:0]   wr_ptr;
	logic [PTR_W:0]   rd_ptr;
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W-1:0] scan_idx;
	logic [PTR_W-1:0] fill_idx;
	logic             fill_hit;
	logic             retire;

	assign head = rd_ptr[PTR_W-1:0];
	assign tail = wr_ptr[PTR_W-1:0];

	assign not_full  = ((wr_ptr - rd_ptr) != (PTR_W+1)'(DEPTH));
	assign out_valid = alloc_q[head] && filled_q[head];   // Head must be complete
	assign out       = data_q[head];
	assign retire    = out_valid && out_ready;

	// ------------------------------
	// Tag match from the oldest entry
	// ------------------------------
	always_comb
	begin
		fill_hit = 1'b0;
		fill_idx = '0;
		scan_idx = '0;
		for (int k = 0; k < DEPTH; k++)
		begin
			scan_idx = head + PTR_W'(k);
			if (!fill_hit && alloc_q[scan_idx] && !filled_q[scan_idx]
				&& tag_q[scan_idx] == fill_tag)
			begin
				fill_hit = 1'b1;
				fill_idx = scan_idx;
			end
		end
	end

	always_ff @(posedge ACLK)
	begin
		if (!ARESETn)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			alloc_q  <= '0;
			filled_q <= '0;
		end
		else
		begin
			if (alloc)
			begin
				alloc_q[tail]  <= 1'b1;
				filled_q[tail] <= 1'b0;
				wr_ptr         <= wr_ptr + 1'b1;
			end
			if (fill && fill_hit)
				filled_q[fill_idx] <= 1'b1;
			// A retiring head is already filled so no fill lands on it
			if (retire)
			begin
				alloc_q[head]  <= 1'b0;
				filled_q[head] <= 1'b0;
				rd_ptr         <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge ACLK)
	begin
		if (alloc)
			tag_q[tail] <= alloc_tag;
		if (fill && fill_hit)
			data_q[fill_idx] <= fill_data;
	end

	// A response must belong to an outstanding request
	a_fill_matches: assert property (@(posedge ACLK) disable iff (!ARESETn) fill |-> fill_hit)
		else $error("response with no matching reorder entry dropped");

endmodule

`default_nettype wire

/* rtl/response_depacketizer.sv */
`timescale 1ns/1ps
`default_nettype none

module response_depacketizer (
	input  logic                    ACLK,
	input  logic                    ARESETn,
	input  noc_if_pkg::noc_packet_t pkt,           // Inbound FIFO head
	input  logic                    pkt_avail,
	output logic                    pop,
	output logic                    rd_fill,
	output noc_if_pkg::rd_tag_t     rd_fill_tag,
	output noc_if_pkg::r_resp_t     rd_fill_data,
	output logic                    wr_fill,
	output noc_if_pkg::wr_tag_t     wr_fill_tag,
	output noc_if_pkg::b_resp_t     wr_fill_data
);
	import noc_if_pkg::*;

	// Every packet is taken as soon as it shows up
	assign pop = pkt_avail;

	always_ff @(posedge ACLK)
	begin
		if (!ARESETn)
		begin
			rd_fill <= 1'b0;
			wr_fill <= 1'b0;
		end
		else
		begin
			rd_fill <= pop && (pkt.ptype == PT_RD_DATA);   // One-cycle strobes
			wr_fill <= pop && (pkt.ptype == PT_WR_RESP);
		end
	end

	// Tag and payload picked apart by type
	always_ff @(posedge ACLK)
	begin
		if (pop && pkt.ptype == PT_RD_DATA)
		begin
			rd_fill_tag  <= '{seq: pkt.seq};
			rd_fill_data <= '{id: pkt.id, data: pkt.data};
		end
		if (pop && pkt.ptype == PT_WR_RESP)
		begin
			wr_fill_tag  <= '{seq: pkt.seq, dst: pkt.src};          // Responder is the write's slave
			wr_fill_data <= '{id: pkt.id, resp: pkt.data[RESP_W-1:0]};
		end
	end

	// Router should only return responses to a master
	a_known_type: assert property (@(posedge ACLK) disable iff (!ARESETn)
		pop |-> pkt.ptype inside {PT_RD_DATA, PT_WR_RESP})
		else $error("dropped inbound packet of type %0d", pkt.ptype);

endmodule

`default_nettype wire

/* rtl/request_packetizer.sv */
`timescale 1ns/1ps
`default_nettype none

module request_packetizer #(
	parameter logic [noc_if_pkg::NODE_W-1:0] MASTER_ID = '0
) (
	input  logic                    ACLK,
	input  logic                    ARESETn,
	input  noc_if_pkg::aw_req_t     aw,
	input  logic                    aw_valid,
	output logic                    aw_ready,
	input  noc_if_pkg::w_req_t      w,
	input  logic                    w_valid,
	output logic                    w_ready,
	input  noc_if_pkg::ar_req_t     ar,
	input  logic                    ar_valid,
	output logic                    ar_ready,
	input  logic                    fifo_full,
	input  logic                    fifo_one_free,
	input  logic                    wr_rob_not_full,
	input  logic                    rd_rob_not_full,
	output noc_if_pkg::noc_packet_t pkt,
	output logic                    pkt_valid,
	output logic                    wr_alloc,
	output noc_if_pkg::wr_tag_t     wr_alloc_tag,
	output logic                    rd_alloc,
	output noc_if_pkg::rd_tag_t     rd_alloc_tag
);
	import noc_if_pkg::*;

	logic                   room;                  // FIFO takes the register plus one more
	logic                   w_fire;
	logic                   aw_fire;
	logic                   ar_fire;
	logic [SEQ_W-1:0]       wr_ctr [NUM_SLAVES];   // One write sequence per slave
	logic [SEQ_W-1:0]       rd_ctr;
	logic [SEQ_W-1:0]       last_seq;              // Seq of the latest AW for its W
	logic [NODE_W-1:0]      last_dst;
	logic [SLAVE_SEL_W-1:0] aw_sel;
	logic [NODE_W-1:0]      aw_dst;
	noc_packet_t            pkt_next;

	// ------------------------------
	// Readiness and arbitration
	// ------------------------------
	assign room = !fifo_full && !(pkt_valid && fifo_one_free);

	// Fixed priority W, AW, AR. W allocates nothing so skips the ROB check
	assign w_ready  = room;
	assign aw_ready = room && wr_rob_not_full && !w_valid;
	assign ar_ready = room && rd_rob_not_full && !w_valid && !aw_fire;

	assign w_fire  = w_valid && w_ready;
	assign aw_fire = aw_valid && aw_ready;
	assign ar_fire = ar_valid && ar_ready;

	assign aw_sel = aw.addr[SLAVE_SEL_LSB +: SLAVE_SEL_W];
	assign aw_dst = slave_node(aw.addr);

	// Reorder entries open in request order
	assign wr_alloc     = aw_fire;
	assign wr_alloc_tag = '{seq: wr_ctr[aw_sel], dst: aw_dst};
	assign rd_alloc     = ar_fire;
	assign rd_alloc_tag = '{seq: rd_ctr};

	// ------------------------------
	// Packet assembly
	// ------------------------------
	always_comb
	begin
		pkt_next       = '0;
		pkt_next.src   = MASTER_ID;
		pkt_next.valid = 1'b1;
		if (w_fire)
		begin
			pkt_next.data  = w.data;
			pkt_next.id    = w.id;
			pkt_next.seq   = last_seq;           // Follows the preceding AW
			pkt_next.dst   = last_dst;
			pkt_next.ptype = PT_WR_DATA;
		end
		else if (aw_fire)
		begin
			pkt_next.data[ADDR_W-1:0] = aw.addr;
			pkt_next.id    = aw.id;
			pkt_next.seq   = wr_ctr[aw_sel];
			pkt_next.dst   = aw_dst;
			pkt_next.ptype = PT_WR_ADDR;
		end
		else
		begin
			pkt_next.data[ADDR_W-1:0] = ar.addr;
			pkt_next.id    = ar.id;
			pkt_next.seq   = rd_ctr;
			pkt_next.dst   = slave_node(ar.addr);
			pkt_next.ptype = PT_RD_ADDR;
		end
	end

	always_ff @(posedge ACLK)
	begin
		if (!ARESETn)
		begin
			pkt_valid <= 1'b0;
			rd_ctr    <= '0;
			last_seq  <= '0;
			last_dst  <= '0;
			for (int s = 0; s < NUM_SLAVES; s++)
				wr_ctr[s] <= '0;
		end
		else
		begin
			pkt_valid <= w_fire || aw_fire || ar_fire;   // Drained into the FIFO next edge
			if (aw_fire)
			begin
				wr_ctr[aw_sel] <= wr_ctr[aw_sel] + 1'b1;
				last_seq       <= wr_ctr[aw_sel];
				last_dst       <= aw_dst;
			end
			if (ar_fire)
				rd_ctr <= rd_ctr + 1'b1;
		end
	end

	always_ff @(posedge ACLK)
	begin
		if (w_fire || aw_fire || ar_fire)
			pkt <= pkt_next;
	end

	// Readiness one cycle earlier must leave a slot for the register
	a_pkt_has_slot: assert property (@(posedge ACLK) disable iff (!ARESETn)
		pkt_valid |-> !fifo_full)
		else $error("packet register loaded with no FIFO slot");

endmodule

`default_nettype wire

/* rtl/packet_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_fifo #(
	parameter int  DEPTH = 8,              // Power of two
	parameter type T     = logic [7:0]
) (
	input  logic ACLK,
	input  logic ARESETn,
	input  logic put,
	input  logic get,
	input  T     din,
	output T     dout,
	output logic empty,
	output logic full,
	output logic one_free                 // Exactly one slot left
);
	localparam int AW = $clog2(DEPTH);

	T            mem [DEPTH];             // Packet storage
	logic [AW:0] wr_ptr;                  // Extra MSB tells full from empty
	logic [AW:0] rd_ptr;
	logic [AW:0] count;
	logic        do_put;
	logic        do_get;

	assign count    = wr_ptr - rd_ptr;
	assign empty    = (wr_ptr == rd_ptr);
	assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign one_free = (count == (AW+1)'(DEPTH - 1));

	assign do_put = put && !full;         // Overflow attempt is dropped
	assign do_get = get && !empty;

	// First word falls through
	assign dout = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge ACLK)
	begin
		if (!ARESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_put)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_get)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge ACLK)
	begin
		if (do_put)
			mem[wr_ptr[AW-1:0]] <= din;
	end

	// Producer and consumer must respect the flags
	a_no_overflow: assert property (@(posedge ACLK) disable iff (!ARESETn) put |-> !full)
		else $error("packet_fifo put while full");
	a_no_underflow: assert property (@(posedge ACLK) disable iff (!ARESETn) get |-> !empty)
		else $error("packet_fifo get while empty");

endmodule

`default_nettype wire

/* rtl/noc_if_pkg.sv */
`default_nettype none

package noc_if_pkg;

	// ------------------------------
	// Widths and sizes
	// ------------------------------
	localparam int ADDR_W          = 32;    // AXI address
	localparam int DATA_W          = 128;   // AXI data and packet payload
	localparam int ID_W            = 3;     // Transaction ID
	localparam int SEQ_W           = 3;     // Sequence counters
	localparam int NODE_W          = 3;     // NoC node ID
	localparam int PKT_W           = 160;
	localparam int PTYPE_W         = 3;
	localparam int RESP_W          = 2;     // Write response code
	localparam int SLAVE_SEL_LSB   = 4;     // Address bits [5:4] pick the slave
	localparam int SLAVE_SEL_W     = 2;
	localparam int NUM_SLAVES      = 4;
	localparam int SLAVE_NODE_BASE = 4;     // Slave k sits on node 4+k

	// Whatever the header leaves over is zero pad
	localparam int PAD_W = PKT_W - DATA_W - ID_W - SEQ_W - 2 * NODE_W - PTYPE_W - 1;

	typedef enum logic [PTYPE_W-1:0] {
		PT_WR_ADDR = 3'd0,
		PT_WR_DATA = 3'd1,
		PT_RD_ADDR = 3'd2,
		PT_WR_RESP = 3'd3,
		PT_RD_DATA = 3'd4
	} ptype_e;

	// ------------------------------
	// Packet and channel structs
	// ------------------------------
	typedef struct packed {
		logic [DATA_W-1:0] data;     // Address in [31:0] or write resp code in [1:0]
		logic [ID_W-1:0]   id;
		logic [SEQ_W-1:0]  seq;
		logic [NODE_W-1:0] src;
		logic [NODE_W-1:0] dst;
		ptype_e            ptype;
		logic              valid;
		logic [PAD_W-1:0]  pad;
	} noc_packet_t;

	typedef struct packed { logic [ID_W-1:0] id; logic [ADDR_W-1:0] addr; } aw_req_t;
	typedef struct packed { logic [ID_W-1:0] id; logic [DATA_W-1:0] data; } w_req_t;
	typedef struct packed { logic [ID_W-1:0] id; logic [ADDR_W-1:0] addr; } ar_req_t;
	typedef struct packed { logic [ID_W-1:0] id; logic [DATA_W-1:0] data; } r_resp_t;
	typedef struct packed { logic [ID_W-1:0] id; logic [RESP_W-1:0] resp; } b_resp_t;

	// Write tags match on slave and per-slave sequence
	typedef struct packed { logic [SEQ_W-1:0] seq; logic [NODE_W-1:0] dst; } wr_tag_t;
	typedef struct packed { logic [SEQ_W-1:0] seq; } rd_tag_t;

	// Node ID of the slave that an address decodes to
	function automatic logic [NODE_W-1:0] slave_node(input logic [ADDR_W-1:0] addr);
		return NODE_W'(SLAVE_NODE_BASE) + NODE_W'(addr[SLAVE_SEL_LSB +: SLAVE_SEL_W]);
	endfunction

endpackage

`default_nettype wire
